//--- bench/tb_clk.sv
`timescale 1ns/1ps

module tb_clk (
   output logic clk
);

   localparam realtime HALF_PERIOD = 2.0;  // 4 ns period

   initial begin
      clk = 1'b0;
      forever begin
         #(HALF_PERIOD) clk = ~clk;
      end
   end

endmodule

//--- bench/tb_top.sv
`timescale 1ns/1ps

module tb_top import sys_pkg::*; ();

   localparam int RESET_CYCLES = 10;
   localparam int QUIET_CYCLES = LOCK_CYCLES + CAL_CYCLES;
   localparam int BOUND_CYCLES = LOCK_CYCLES + CAL_CYCLES + 2 + 2 * WIN_WORDS * 5 + 200;
   localparam int HOLD_CYCLES  = 20;   // trap watched after it rises
   localparam int RUNS         = 2;    // Second run follows a reset reassert
   localparam int WATCHDOG_CYCLES =
      RUNS * (RESET_CYCLES + BOUND_CYCLES + HOLD_CYCLES + 2) + 100;

   logic clk;
   logic rst_n;
   logic trap;
   logic test_err;
   logic trap_seen;

   int   value_errs;
   int   seq_errs;
   int   chk_errs;
   int   total_errs;

   tb_clk clk_gen (
      .clk (clk)
   );

   top_system top_system_inst (
      .clk      (clk),
      .rst_n    (rst_n),
      .trap     (trap),
      .test_err (test_err)
   );

   // --------------------
   // Checks
   // --------------------
   task automatic check_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else begin
         value_errs++;
         $display("Fail %0d ns: %s expected %0b, got %0b", $time, name, exp, act);
      end
   endtask

   task automatic check_quiet();
      check_bit("trap", 1'b0, trap);
      check_bit("test_err", 1'b0, test_err);
   endtask

   // trap sticks until reset, test_err low whenever trap is up
   always @(posedge clk) begin
      if (!rst_n) begin
         trap_seen = 1'b0;
      end else begin
         if (trap_seen) begin
            check_bit("trap", 1'b1, trap);
         end
         if (trap === 1'b1) begin
            check_bit("test_err", 1'b0, test_err);
            trap_seen = 1'b1;
         end
      end
   end

   // --------------------
   // Stimulus
   // --------------------
   task automatic apply_reset();
      @(negedge clk);
      rst_n = 1'b0;
      #1;
      check_quiet();  // Outputs drop without waiting for a clock
      repeat (RESET_CYCLES) begin
         @(posedge clk);
         check_quiet();
      end
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   task automatic wait_for_trap(input int max_cycles);
      int n;
      n = 0;
      while (trap !== 1'b1 && n < max_cycles) begin
         @(posedge clk);
         n++;
      end
      assert (trap === 1'b1) else begin
         seq_errs++;
         $display("trap did not rise within %0d cycles of reset release", BOUND_CYCLES);
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      trap_seen  = 1'b0;
      value_errs = 0;
      seq_errs   = 0;
      chk_errs   = 0;

      for (int run = 0; run < RUNS; run++) begin
         apply_reset();
         repeat (QUIET_CYCLES) begin  // Lock and calibration still running
            @(posedge clk);
            check_quiet();
         end
         wait_for_trap(BOUND_CYCLES - QUIET_CYCLES);
         repeat (HOLD_CYCLES) @(posedge clk);
      end

      chk_errs   = int'(top_system_inst.chk_inst.fail_count);
      total_errs = value_errs + seq_errs + chk_errs;
      $display("Errors: %0d value, %0d sequence, %0d assertion, %0d total",
               value_errs, seq_errs, chk_errs, total_errs);
      if (total_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

   // --------------------
   // Watchdog
   // --------------------
   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Run timed out after %0d clock cycles", WATCHDOG_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

endmodule

//--- bench/top_system_chk.sv
`timescale 1ns/1ps

module top_system_chk import sys_pkg::*; (
   input logic     clk,
   input logic     rst_n,
   input logic     sys_rst_n,
   input logic     trap,
   input logic     test_err,
   input mem_req_t req0,
   input mem_rsp_t rsp0,
   input mem_req_t req1,
   input mem_rsp_t rsp1
);

   int unsigned fail_count = 0;  // Read by the testbench at the end

   // --------------------
   // Arbitration
   // --------------------
   gnt_exclusive: assert property (@(posedge clk) disable iff (!sys_rst_n)
      !(rsp0.gnt && rsp1.gnt))
   else begin
      fail_count++;
      $error("gnt high on both ports in one cycle");
   end

   // Granted read returns data on the next cycle
   rd0_latency: assert property (@(posedge clk) disable iff (!sys_rst_n)
      (rsp0.gnt && !req0.we) |=> rsp0.rvalid)
   else begin
      fail_count++;
      $error("port 0 read granted without rvalid one cycle later");
   end

   rd1_latency: assert property (@(posedge clk) disable iff (!sys_rst_n)
      (rsp1.gnt && !req1.we) |=> rsp1.rvalid)
   else begin
      fail_count++;
      $error("port 1 read granted without rvalid one cycle later");
   end

   // No stray read data
   rv0_origin: assert property (@(posedge clk) disable iff (!sys_rst_n)
      rsp0.rvalid |-> $past(rsp0.gnt && !req0.we))
   else begin
      fail_count++;
      $error("port 0 rvalid without a granted read");
   end

   rv1_origin: assert property (@(posedge clk) disable iff (!sys_rst_n)
      rsp1.rvalid |-> $past(rsp1.gnt && !req1.we))
   else begin
      fail_count++;
      $error("port 1 rvalid without a granted read");
   end

   // --------------------
   // Reset
   // --------------------
   out_low_in_reset: assert property (@(posedge clk)
      (!rst_n || !sys_rst_n) |-> (!trap && !test_err))
   else begin
      fail_count++;
      $error("trap or test_err high while in reset");
   end

endmodule

bind top_system top_system_chk chk_inst (
   .clk       (clk),
   .rst_n     (rst_n),
   .sys_rst_n (sys_rst_n),
   .trap      (trap),
   .test_err  (test_err),
   .req0      (tester_req),
   .rsp0      (tester_rsp),
   .req1      (sut_req),
   .rsp1      (sut_rsp)
);

//--- files.f
logic/sys_pkg.sv
logic/reset_sync.sv
logic/mem_tester.sv
logic/mem_interconnect.sv
logic/ram_ctrl.sv
logic/top_system.sv
bench/tb_clk.sv
bench/top_system_chk.sv
bench/tb_top.sv

//--- logic/mem_interconnect.sv
`timescale 1ns/1ps

module mem_interconnect import sys_pkg::*; (
   input  logic              clk,
   input  logic              sys_rst_n,
   input  mem_req_t          req0,
   input  mem_req_t          req1,
   output mem_rsp_t          rsp0,
   output mem_rsp_t          rsp1,
   output mem_req_t          mem_req,
   input  logic              mem_rvalid,
   input  logic [DATA_W-1:0] mem_rdata
);

   arb_owner_t last_owner;  // Port that won most recently
   arb_owner_t rd_tag;      // Port owning the read in flight
   logic       sel1;

   // --------------------
   // Round-robin pick
   // --------------------
   // Port 1 wins alone, or on contention when port 0 went last
   assign sel1 = req1.req && (!req0.req || (last_owner == OWN_0));

   assign mem_req = sel1 ? req1 : req0;  // Idle port 0 carries req low

   always_ff @(posedge clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         last_owner <= OWN_1;  // Port 0 first on a tie
         rd_tag     <= OWN_0;
      end else begin
         if (mem_req.req) begin
            last_owner <= sel1 ? OWN_1 : OWN_0;
         end
         if (mem_req.req && !mem_req.we) begin
            rd_tag <= sel1 ? OWN_1 : OWN_0;
         end
      end
   end

   // --------------------
   // Response routing
   // --------------------
   always_comb begin
      rsp0.gnt    = req0.req && !sel1;
      rsp0.rvalid = mem_rvalid && (rd_tag == OWN_0);
      rsp0.rdata  = mem_rdata;
      rsp1.gnt    = sel1;
      rsp1.rvalid = mem_rvalid && (rd_tag == OWN_1);
      rsp1.rdata  = mem_rdata;
   end

endmodule

//--- logic/mem_tester.sv
`timescale 1ns/1ps

module mem_tester import sys_pkg::*; #(
   parameter logic [ADDR_W-1:0] BASE = '0,
   parameter logic [DATA_W-1:0] SEED = 32'd1  // Must be nonzero
) (
   input  logic     clk,
   input  logic     sys_rst_n,
   output mem_req_t req,
   input  mem_rsp_t rsp,
   output logic     trap,
   output logic     err
);

   tester_state_t         state;
   logic [WIN_IDX_W-1:0]  idx;      // Word offset inside the window
   logic [DATA_W-1:0]     pattern;  // Current xorshift value
   logic                  last_word;

   // xorshift32 step, shifts 13/17/5
   function automatic logic [DATA_W-1:0] xorshift32(input logic [DATA_W-1:0] x);
      logic [DATA_W-1:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   assign last_word = (idx == WIN_IDX_W'(WIN_WORDS - 1));

   // --------------------
   // Request drive
   // --------------------
   always_comb begin
      req       = '0;
      req.addr  = BASE + ADDR_W'(idx);
      req.wdata = pattern;
      unique case (state)
         T_WRITE: begin
            req.req = 1'b1;
            req.we  = 1'b1;
         end
         T_READ: begin
            req.req = 1'b1;  // we stays low
         end
         default: begin
            req.req = 1'b0;
         end
      endcase
   end

   // --------------------
   // Sequencer
   // --------------------
   always_ff @(posedge clk or negedge sys_rst_n) begin
      if (!sys_rst_n) begin
         state   <= T_IDLE;
         idx     <= '0;
         pattern <= SEED;
         err     <= 1'b0;
      end else begin
         unique case (state)
            T_IDLE: begin
               idx     <= '0;
               pattern <= SEED;
               state   <= T_WRITE;
            end

            T_WRITE: begin
               if (rsp.gnt) begin
                  if (last_word) begin
                     idx     <= '0;
                     pattern <= SEED;  // Replay sequence for read-back
                     state   <= T_READ;
                  end else begin
                     idx     <= idx + 1'b1;
                     pattern <= xorshift32(pattern);
                  end
               end
            end

            T_READ: begin
               if (rsp.gnt) begin
                  state <= T_WAIT;
               end
            end

            T_WAIT: begin
               if (rsp.rvalid) begin
                  if (rsp.rdata != pattern) begin
                     err <= 1'b1;  // Sticky until reset
                  end
                  pattern <= xorshift32(pattern);
                  if (last_word) begin
                     state <= T_DONE;
                  end else begin
                     idx   <= idx + 1'b1;
                     state <= T_READ;
                  end
               end
            end

            T_DONE: begin
               state <= T_DONE;
            end

            default: begin
               state <= T_IDLE;
            end
         endcase
      end
   end

   assign trap = (state == T_DONE);

endmodule

//--- logic/ram_ctrl.sv
`timescale 1ns/1ps

module ram_ctrl import sys_pkg::*; (
   input  logic              clk,
   input  logic              rst_n,
   input  mem_req_t          req,
   output logic              rvalid,
   output logic [DATA_W-1:0] rdata,
   output logic              locked,
   output logic              init_done
);

   localparam logic [INIT_CNT_W-1:0] LOCK_AT = INIT_CNT_W'(LOCK_CYCLES);
   localparam logic [INIT_CNT_W-1:0] CAL_AT  = INIT_CNT_W'(LOCK_CYCLES + CAL_CYCLES);

   logic [INIT_CNT_W-1:0] init_cnt;
   logic [DATA_W-1:0]     mem [MEM_WORDS];
   logic                  rd_en;
   logic                  wr_en;

   // --------------------
   // Lock and calibration
   // --------------------
   // One counter covers PLL lock, then calibration
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_cnt <= '0;
      end else if (init_cnt != CAL_AT) begin
         init_cnt <= init_cnt + 1'b1;  // Saturates at CAL_AT
      end
   end

   assign locked    = (init_cnt >= LOCK_AT);
   assign init_done = (init_cnt == CAL_AT);

   // --------------------
   // Storage
   // --------------------
   assign wr_en = req.req && req.we;
   assign rd_en = req.req && !req.we;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[req.addr] <= req.wdata;
      end
      if (rd_en) begin
         rdata <= mem[req.addr];  // Ready one cycle after accept
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rvalid <= 1'b0;
      end else begin
         rvalid <= rd_en;
      end
   end

endmodule

//--- logic/reset_sync.sv
`timescale 1ns/1ps

module reset_sync import sys_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   input  logic locked,
   input  logic init_done,
   output logic sys_rst_n
);

   logic                   clr_n;
   logic [SYNC_STAGES-1:0] sync_q;

   // System stays in reset until board, PLL and calibration are all ready
   assign clr_n = rst_n & locked & init_done;

   // Assert immediately, release after SYNC_STAGES edges
   always_ff @(posedge clk or negedge clr_n) begin
      if (!clr_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
      end
   end

   assign sys_rst_n = sync_q[SYNC_STAGES-1];

endmodule

//--- logic/sys_pkg.sv
package sys_pkg;

   // --------------------
   // Memory geometry
   // --------------------
   localparam int ADDR_W    = 10;
   localparam int DATA_W    = 32;
   localparam int MEM_WORDS = 2 ** ADDR_W;

   // Words tested per requester
   localparam int WIN_WORDS = 64;
   localparam int WIN_IDX_W = $clog2(WIN_WORDS);

   // --------------------
   // Bring-up timing
   // --------------------
   localparam int LOCK_CYCLES = 8;   // rst_n high to PLL locked
   localparam int CAL_CYCLES  = 32;  // locked to calibration done
   localparam int INIT_CNT_W  = $clog2(LOCK_CYCLES + CAL_CYCLES + 1);
   localparam int SYNC_STAGES = 2;   // Reset release flops

   // Requester windows and pattern seeds
   localparam logic [ADDR_W-1:0] TESTER_BASE = 10'd0;
   localparam logic [ADDR_W-1:0] SUT_BASE    = 10'd512;
   localparam logic [DATA_W-1:0] TESTER_SEED = 32'd1;
   localparam logic [DATA_W-1:0] SUT_SEED    = 32'd7;

   // --------------------
   // Port structs
   // --------------------
   typedef struct packed {
      logic              req;   // Level request, held until gnt
      logic              we;    // 1 write, 0 read
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } mem_req_t;

   typedef struct packed {
      logic              gnt;     // Access taken this cycle
      logic              rvalid;  // Read data, one cycle after gnt
      logic [DATA_W-1:0] rdata;
   } mem_rsp_t;

   typedef enum logic [2:0] {
      T_IDLE,
      T_WRITE,
      T_READ,
      T_WAIT,
      T_DONE
   } tester_state_t;

   typedef enum logic {
      OWN_0,
      OWN_1
   } arb_owner_t;

endpackage

//--- logic/top_system.sv
`timescale 1ns/1ps

module top_system import sys_pkg::*; (
   input  logic clk,
   input  logic rst_n,
   output logic trap,
   output logic test_err
);

   logic              sys_rst_n;
   logic              locked;
   logic              init_done;

   mem_req_t          tester_req;
   mem_rsp_t          tester_rsp;
   mem_req_t          sut_req;
   mem_rsp_t          sut_rsp;

   mem_req_t          mem_req;
   logic              mem_rvalid;
   logic [DATA_W-1:0] mem_rdata;

   logic [1:0]        trap_signals;  // 0 tester, 1 SUT
   logic [1:0]        err_signals;

   // --------------------
   // Reset and memory
   // --------------------
   reset_sync rst_sync (
      .clk       (clk),
      .rst_n     (rst_n),
      .locked    (locked),
      .init_done (init_done),
      .sys_rst_n (sys_rst_n)
   );

   // Memory side runs from the board reset
   ram_ctrl ram_ctrl_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .req       (mem_req),
      .rvalid    (mem_rvalid),
      .rdata     (mem_rdata),
      .locked    (locked),
      .init_done (init_done)
   );

   // Both requesters share the one controller
   mem_interconnect interconnect_inst (
      .clk        (clk),
      .sys_rst_n  (sys_rst_n),
      .req0       (tester_req),
      .req1       (sut_req),
      .rsp0       (tester_rsp),
      .rsp1       (sut_rsp),
      .mem_req    (mem_req),
      .mem_rvalid (mem_rvalid),
      .mem_rdata  (mem_rdata)
   );

   // --------------------
   // Requesters
   // --------------------
   mem_tester #(
      .BASE (TESTER_BASE),
      .SEED (TESTER_SEED)
   ) tester_inst (
      .clk       (clk),
      .sys_rst_n (sys_rst_n),
      .req       (tester_req),
      .rsp       (tester_rsp),
      .trap      (trap_signals[0]),
      .err       (err_signals[0])
   );

   // Stand-in for the unit under test
   mem_tester #(
      .BASE (SUT_BASE),
      .SEED (SUT_SEED)
   ) sut_inst (
      .clk       (clk),
      .sys_rst_n (sys_rst_n),
      .req       (sut_req),
      .rsp       (sut_rsp),
      .trap      (trap_signals[1]),
      .err       (err_signals[1])
   );

   assign trap     = trap_signals[0] | trap_signals[1];
   assign test_err = err_signals[0] | err_signals[1];

endmodule

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module tb_top \
   -Mdir obj_dir -o sim_tb_top \
   -f files.f

# Let the testbench finish and print its summary after assertion errors
./obj_dir/sim_tb_top +verilator+error+limit+1000 > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "=== PASS ===" "$LOG"; then
   echo "Simulation passed"
   exit 0
else
   echo "Simulation failed, see $LOG"
   exit 1
fi
